// File: verilog/gba_io_macros.svh
// Widths and counts for the I/O block. Changing the timer or LED counts
// also needs matching offsets in gba_bus_pkg.
`ifndef GBA_IO_MACROS_SVH
`define GBA_IO_MACROS_SVH

// Halfword bus
`define GBA_DATA_W 16

// Timers 0 to 3
`define GBA_NUM_TIMERS 4

// Free-running prescaler, 1024 divide at full count
`define GBA_PRESCALE_W 10

// LED debug registers
`define GBA_NUM_LED_REGS 4

`endif

// File: verilog/gba_bus_pkg.sv
// CPU-side I/O bus types. Offsets are halfword indices and anything
// not listed in reg_offset_e reads zero.
`include "gba_io_macros.svh"

package gba_bus_pkg;

    // Timer offsets pair up as L at 2n, H at 2n+1
    typedef enum logic [5:0] {
        TM0CNT_L = 6'h00,
        TM0CNT_H = 6'h01,
        TM1CNT_L = 6'h02,
        TM1CNT_H = 6'h03,
        TM2CNT_L = 6'h04,
        TM2CNT_H = 6'h05,
        TM3CNT_L = 6'h06,
        TM3CNT_H = 6'h07,
        IE_OFS   = 6'h08,
        IF_OFS   = 6'h09,
        IME_OFS  = 6'h0a,
        LED0_OFS = 6'h10,
        LED1_OFS = 6'h11,
        LED2_OFS = 6'h12,
        LED3_OFS = 6'h13
    } reg_offset_e;

    typedef struct packed {
        logic                   rd;
        logic                   wr;
        reg_offset_e            addr;
        logic [`GBA_DATA_W-1:0] wdata;
    } io_req_t;

    typedef struct packed {
        logic                   rvalid;
        logic [`GBA_DATA_W-1:0] rdata;
    } io_rsp_t;

endpackage

// File: verilog/gba_periph_pkg.sv
// Peripheral state types. The timer control word sits in the low bits
// of TMxCNT_H, start at the top.
`include "gba_io_macros.svh"

package gba_periph_pkg;

    // prescale 0..3 selects a divide of 1, 64, 256, 1024
    typedef struct packed {
        logic       start;
        logic       irq_en;
        logic       cascade;
        logic [1:0] prescale;
    } tmr_ctrl_t;

    // Bit positions in IF, only the timer sources exist here
    typedef enum logic [3:0] {
        IRQ_TIMER0 = 4'd3,
        IRQ_TIMER1 = 4'd4,
        IRQ_TIMER2 = 4'd5,
        IRQ_TIMER3 = 4'd6
    } irq_src_e;

    // ovf pulses on every wrap, req only with irq_en set
    typedef struct packed {
        logic [`GBA_NUM_TIMERS-1:0] ovf;
        logic [`GBA_NUM_TIMERS-1:0] req;
    } tmr_event_t;

endpackage

// File: verilog/io_reg_file.sv
// Register block for timers, IE/IME and the LED debug mux. Bus strobes are
// single cycle; read data returns one cycle later and reads never side-effect.
`timescale 1ns/1ps
`include "gba_io_macros.svh"

module io_reg_file (
    input  logic                                           gba_clk,
    input  logic                                           rst,
    input  gba_bus_pkg::io_req_t                           req,
    output gba_bus_pkg::io_rsp_t                           rsp,
    input  logic [15:0]                                    buttons,
    input  logic [7:0]                                     sw,
    output logic [7:0]                                     ld,
    input  logic [`GBA_NUM_TIMERS-1:0][`GBA_DATA_W-1:0]    tmr_count,
    input  logic [`GBA_DATA_W-1:0]                         if_flags,
    output logic [`GBA_NUM_TIMERS-1:0][`GBA_DATA_W-1:0]    tmr_reload,
    output gba_periph_pkg::tmr_ctrl_t [`GBA_NUM_TIMERS-1:0] tmr_ctrl,
    output logic [`GBA_NUM_TIMERS-1:0]                     tmr_load,
    output logic [`GBA_DATA_W-1:0]                         ie,
    output logic                                           ime,
    output logic [`GBA_DATA_W-1:0]                         if_ack
);
    import gba_bus_pkg::*;
    import gba_periph_pkg::*;

    localparam int CTRL_W    = $bits(tmr_ctrl_t);
    localparam int TMR_IDX_W = $clog2(`GBA_NUM_TIMERS);
    localparam int LED_IDX_W = $clog2(`GBA_NUM_LED_REGS);

    logic [`GBA_NUM_LED_REGS-1:0][`GBA_DATA_W-1:0] led_q;
    logic [`GBA_DATA_W-1:0]                       rdata_d;
    logic [TMR_IDX_W-1:0]                         tmr_idx;
    logic [LED_IDX_W-1:0]                         led_idx;
    logic [LED_IDX_W-1:0]                         led_sel;
    tmr_ctrl_t                                    new_ctrl;
    logic sel_tmr_l;
    logic sel_tmr_h;
    logic sel_ie;
    logic sel_if;
    logic sel_ime;
    logic sel_led;

    assign tmr_idx  = req.addr[TMR_IDX_W:1];
    assign led_idx  = req.addr[LED_IDX_W-1:0];
    assign new_ctrl = tmr_ctrl_t'(req.wdata[CTRL_W-1:0]);

    // Offset decode, shared by reads and writes
    always_comb begin
        sel_tmr_l = 1'b0;
        sel_tmr_h = 1'b0;
        sel_ie    = 1'b0;
        sel_if    = 1'b0;
        sel_ime   = 1'b0;
        sel_led   = 1'b0;
        case (req.addr)
            TM0CNT_L, TM1CNT_L, TM2CNT_L, TM3CNT_L: sel_tmr_l = 1'b1;
            TM0CNT_H, TM1CNT_H, TM2CNT_H, TM3CNT_H: sel_tmr_h = 1'b1;
            IE_OFS:   sel_ie  = 1'b1;
            IF_OFS:   sel_if  = 1'b1;
            IME_OFS:  sel_ime = 1'b1;
            LED0_OFS, LED1_OFS, LED2_OFS, LED3_OFS: sel_led = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge gba_clk) begin
        if (rst) begin
            tmr_reload <= '0;
            tmr_ctrl   <= '0;
            ie         <= '0;
            ime        <= 1'b0;
            led_q      <= '0;
        end else if (req.wr) begin
            if (sel_tmr_l)
                tmr_reload[tmr_idx] <= req.wdata;
            if (sel_tmr_h)
                tmr_ctrl[tmr_idx] <= new_ctrl;
            if (sel_ie)
                ie <= req.wdata;
            if (sel_ime)
                ime <= req.wdata[0];
            if (sel_led)
                led_q[led_idx] <= req.wdata;
        end
    end

    // Load only on the rising edge of start, so rewrites of a running timer keep counting
    always_comb begin
        for (int i = 0; i < `GBA_NUM_TIMERS; i++) begin
            tmr_load[i] = req.wr && sel_tmr_h && (tmr_idx == TMR_IDX_W'(i)) &&
                          new_ctrl.start && !tmr_ctrl[i].start;
        end
    end

    assign if_ack = (req.wr && sel_if) ? req.wdata : '0;

    always_comb begin
        rdata_d = '0;
        if (sel_tmr_l)
            rdata_d = tmr_count[tmr_idx];
        else if (sel_tmr_h)
            rdata_d[CTRL_W-1:0] = tmr_ctrl[tmr_idx];
        else if (sel_ie)
            rdata_d = ie;
        else if (sel_if)
            rdata_d = if_flags;
        else if (sel_ime)
            rdata_d[0] = ime;
        else if (sel_led)
            rdata_d = led_q[led_idx];
    end

    always_ff @(posedge gba_clk) begin
        if (rst) begin
            rsp <= '0;
        end else begin
            rsp.rvalid <= req.rd;
            rsp.rdata  <= rdata_d;
        end
    end

    // LED mux, two bytes per LED register
    assign led_sel = sw[LED_IDX_W:1];

    always_comb begin
        if (sw < 8'(2 * `GBA_NUM_LED_REGS))
            ld = sw[0] ? led_q[led_sel][15:8] : led_q[led_sel][7:0];
        else
            ld = sw[7] ? ~buttons[15:8] : ~buttons[7:0];
    end

endmodule

// File: verilog/timer_bank.sv
// Four 16-bit up-counters on one free-running prescaler. Overflow events
// are combinational and cascade ripples through in the same cycle.
`timescale 1ns/1ps
`include "gba_io_macros.svh"

module timer_bank (
    input  logic                                           gba_clk,
    input  logic                                           rst,
    input  logic [`GBA_NUM_TIMERS-1:0][`GBA_DATA_W-1:0]    tmr_reload,
    input  gba_periph_pkg::tmr_ctrl_t [`GBA_NUM_TIMERS-1:0] tmr_ctrl,
    input  logic [`GBA_NUM_TIMERS-1:0]                     tmr_load,
    output logic [`GBA_NUM_TIMERS-1:0][`GBA_DATA_W-1:0]    tmr_count,
    output gba_periph_pkg::tmr_event_t                     tmr_events
);
    import gba_periph_pkg::*;

    logic [`GBA_PRESCALE_W-1:0]                   pre_cnt;
    logic [3:0]                                   pre_tick;
    logic [`GBA_NUM_TIMERS-1:0][`GBA_DATA_W-1:0] count_q;
    logic [`GBA_NUM_TIMERS-1:0]                   tick;
    logic [`GBA_NUM_TIMERS-1:0]                   ovf;

    // Ticks aligned to the prescaler count wrapping its low bits
    assign pre_tick[0] = 1'b1;
    assign pre_tick[1] = (pre_cnt[5:0] == '0);
    assign pre_tick[2] = (pre_cnt[7:0] == '0);
    assign pre_tick[3] = (pre_cnt == '0);

    always_comb begin
        logic casc;
        logic src;
        casc = 1'b0;
        for (int i = 0; i < `GBA_NUM_TIMERS; i++) begin
            // Timer 0 has nothing below it to cascade from
            if (tmr_ctrl[i].cascade && i != 0)
                src = casc;
            else
                src = pre_tick[tmr_ctrl[i].prescale];
            tick[i] = tmr_ctrl[i].start && src;
            ovf[i]  = tick[i] && (count_q[i] == '1);
            tmr_events.ovf[i] = ovf[i];
            tmr_events.req[i] = ovf[i] && tmr_ctrl[i].irq_en;
            casc = ovf[i];
        end
    end

    always_ff @(posedge gba_clk) begin
        if (rst) begin
            pre_cnt <= '0;
            count_q <= '0;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
            for (int i = 0; i < `GBA_NUM_TIMERS; i++) begin
                if (tmr_load[i] || ovf[i])
                    count_q[i] <= tmr_reload[i];
                else if (tick[i])
                    count_q[i] <= count_q[i] + 1'b1;
            end
        end
    end

    assign tmr_count = count_q;

endmodule

// File: verilog/interrupt_controller.sv
// IF holds timer requests until acknowledged; a set beats an ack on the
// same bit. irq is registered and follows IF by one cycle.
`timescale 1ns/1ps
`include "gba_io_macros.svh"

module interrupt_controller (
    input  logic                       gba_clk,
    input  logic                       rst,
    input  gba_periph_pkg::tmr_event_t tmr_events,
    input  logic [`GBA_DATA_W-1:0]     ie,
    input  logic                       ime,
    input  logic [`GBA_DATA_W-1:0]     if_ack,
    output logic [`GBA_DATA_W-1:0]     if_flags,
    output logic                       irq
);
    import gba_periph_pkg::*;

    logic [`GBA_DATA_W-1:0] if_q;
    logic [`GBA_DATA_W-1:0] if_set;

    always_comb begin
        if_set = '0;
        if_set[IRQ_TIMER0] = tmr_events.req[0];
        if_set[IRQ_TIMER1] = tmr_events.req[1];
        if_set[IRQ_TIMER2] = tmr_events.req[2];
        if_set[IRQ_TIMER3] = tmr_events.req[3];
    end

    always_ff @(posedge gba_clk) begin
        if (rst) begin
            if_q <= '0;
            irq  <= 1'b0;
        end else begin
            if_q <= (if_q & ~if_ack) | if_set;
            irq  <= ime && |(ie & if_q);
        end
    end

    assign if_flags = if_q;

endmodule

// File: verilog/gba_io_top.sv
// I/O side of the GBA top level: register block, timers and interrupt
// controller on one clock. Button bits arrive already decoded.
`timescale 1ns/1ps
`include "gba_io_macros.svh"

module gba_io_top (
    input  logic                 gba_clk,
    input  logic                 rst,
    input  gba_bus_pkg::io_req_t req,
    output gba_bus_pkg::io_rsp_t rsp,
    input  logic [15:0]          buttons,
    input  logic [7:0]           sw,
    output logic [7:0]           ld,
    output logic                 irq
);
    import gba_periph_pkg::*;

    logic [`GBA_NUM_TIMERS-1:0][`GBA_DATA_W-1:0] tmr_reload;
    logic [`GBA_NUM_TIMERS-1:0][`GBA_DATA_W-1:0] tmr_count;
    tmr_ctrl_t [`GBA_NUM_TIMERS-1:0]              tmr_ctrl;
    logic [`GBA_NUM_TIMERS-1:0]                   tmr_load;
    tmr_event_t                                   tmr_events;
    logic [`GBA_DATA_W-1:0]                       ie;
    logic                                         ime;
    logic [`GBA_DATA_W-1:0]                       if_ack;
    logic [`GBA_DATA_W-1:0]                       if_flags;

    io_reg_file regs (
        .gba_clk, .rst,
        .req, .rsp,
        .buttons, .sw, .ld,
        .tmr_count, .if_flags,
        .tmr_reload, .tmr_ctrl, .tmr_load,
        .ie, .ime, .if_ack
    );

    timer_bank timers (
        .gba_clk, .rst,
        .tmr_reload, .tmr_ctrl, .tmr_load,
        .tmr_count, .tmr_events
    );

    interrupt_controller intc (
        .gba_clk, .rst,
        .tmr_events,
        .ie, .ime, .if_ack,
        .if_flags, .irq
    );

endmodule

// File: tests/gba_io_chk.sv
// Bus and interrupt rules on the I/O top level, checked only out of reset
`timescale 1ns/1ps

module gba_io_chk (
    input logic                 gba_clk,
    input logic                 rst,
    input gba_bus_pkg::io_req_t req,
    input gba_bus_pkg::io_rsp_t rsp,
    input logic                 ime,
    input logic                 irq
);

    // Read response exactly one cycle after each rd strobe, never otherwise
    rvalid_after_rd: assert property (@(posedge gba_clk) disable iff (rst)
        rsp.rvalid == $past(req.rd))
        else $error("rvalid does not follow rd by exactly one cycle");

    no_rd_wr_overlap: assert property (@(posedge gba_clk) disable iff (rst)
        !(req.rd && req.wr))
        else $error("rd and wr set in the same cycle");

    // irq is registered, so it lags IME by one cycle
    irq_needs_ime: assert property (@(posedge gba_clk) disable iff (rst)
        !$past(ime) |-> !irq)
        else $error("irq high although IME was clear");

endmodule

// File: tests/gba_io_tb.sv
// Self-checking testbench for gba_io_top. Timer counts are only read back
// while the timer is stopped, so the live count needs no model.
`timescale 1ns/1ps

module gba_io_tb;
    import gba_bus_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int NUM_ACKS   = 5;
    // Reset, readback, LED sweep, overflow and ack, cascade, then margin
    localparam int RUN_CYCLES = 10 + 280 + 300 + 200 + NUM_ACKS * 300 + 500;

    logic        gba_clk;
    logic        rst;
    io_req_t     req;
    io_rsp_t     rsp;
    logic [15:0] buttons;
    logic [7:0]  sw;
    logic [7:0]  ld;
    logic        irq;
    int          seed;
    int          value_errors;
    int          other_errors;
    logic [15:0] shadow [0:63];
    logic [15:0] exp_count [0:3];
    logic [15:0] exp_if;
    logic [15:0] exp_q [$];
    string       name_q [$];

    gba_io_top DUT (.gba_clk, .rst, .req, .rsp, .buttons, .sw, .ld, .irq);

    bind gba_io_top gba_io_chk chk (.gba_clk, .rst, .req, .rsp, .ime, .irq);

    initial begin
        gba_clk = 1'b0;
        forever #(CLK_PERIOD / 2) gba_clk = ~gba_clk;
    end

    task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] want);
        if (got !== want) begin
            $display("FAIL %0t ns %s: got %h, expected %h", $time, name, got, want);
            value_errors++;
        end
    endtask

    // Expected readback from the shadow of bus writes
    function automatic logic [15:0] ref_read(input logic [5:0] ofs);
        case (ofs)
            TM0CNT_L, TM1CNT_L, TM2CNT_L, TM3CNT_L: ref_read = exp_count[ofs[2:1]];
            TM0CNT_H, TM1CNT_H, TM2CNT_H, TM3CNT_H: ref_read = shadow[ofs] & 16'h001f;
            IE_OFS, LED0_OFS, LED1_OFS, LED2_OFS, LED3_OFS: ref_read = shadow[ofs];
            IF_OFS:  ref_read = exp_if & 16'h0078;
            IME_OFS: ref_read = shadow[ofs] & 16'h0001;
            default: ref_read = 16'h0000;
        endcase
    endfunction

    function automatic logic [7:0] ref_led(input logic [7:0] s, input logic [15:0] b);
        logic [15:0] word;
        word = shadow[int'(LED0_OFS) + int'(s[2:1])];
        if (s < 8'd8)
            ref_led = s[0] ? word[15:8] : word[7:0];
        else
            ref_led = s[7] ? ~b[15:8] : ~b[7:0];
    endfunction

    // One strobe, then the bus goes idle for a cycle
    task automatic transfer(input logic is_read, input logic [5:0] ofs, input logic [15:0] data);
        @(negedge gba_clk);
        req = '{rd: is_read, wr: !is_read, addr: reg_offset_e'(ofs), wdata: data};
        if (is_read) begin
            exp_q.push_back(ref_read(ofs));
            name_q.push_back($sformatf("rdata[%02h]", ofs));
        end else begin
            shadow[ofs] = data;
        end
        @(negedge gba_clk);
        req = '0;
    endtask

    task automatic wait_irq(input logic level, input int max_cycles, input string what);
        int n;
        n = 0;
        while (irq !== level && n < max_cycles) begin
            @(negedge gba_clk);
            n++;
        end
        if (irq !== level) begin
            $display("ERROR at %0t ns: irq never went %b during %s", $time, level, what);
            other_errors++;
        end
    endtask

    // Each response pairs with the oldest outstanding read
    always @(negedge gba_clk) begin
        if (!rst && rsp.rvalid) begin
            if (exp_q.size() == 0) begin
                $display("ERROR at %0t ns: read response without a read", $time);
                other_errors++;
            end else begin
                check_value(name_q.pop_front(), rsp.rdata, exp_q.pop_front());
            end
        end
    end

    initial begin
        logic [5:0]  ofs;
        logic [15:0] data;
        logic [15:0] reload1;
        int          acks;

        seed         = 32'h0a187189;
        value_errors = 0;
        other_errors = 0;
        exp_if       = '0;
        acks         = 0;
        for (int i = 0; i < 64; i++)
            shadow[i] = '0;
        for (int i = 0; i < 4; i++)
            exp_count[i] = '0;
        rst     = 1'b1;
        req     = '0;
        buttons = '0;
        sw      = '0;
        repeat (10) @(negedge gba_clk);
        rst = 1'b0;

        // Readback with timers stopped, every offset written once
        for (int i = 0; i < 64; i++) begin
            ofs  = 6'(i);
            data = 16'($random(seed));
            if (ofs < 6'h08 && ofs[0])
                data[4] = 1'b0;
            transfer(1'b0, ofs, data);
        end
        for (int i = 0; i < 64; i++)
            transfer(1'b1, 6'(i), '0);

        // LED mux over every switch setting
        for (int i = 0; i < 4; i++)
            transfer(1'b0, 6'(int'(LED0_OFS) + i), 16'($random(seed)));
        for (int s = 0; s < 256; s++) begin
            @(negedge gba_clk);
            sw      = 8'(s);
            buttons = 16'($random(seed));
            @(posedge gba_clk);
            check_value("ld", {8'h00, ld}, {8'h00, ref_led(sw, buttons)});
        end

        // Timer 0 overflow sets IF bit 3, irq only with IME set
        transfer(1'b0, TM0CNT_L, 16'hfff0);
        transfer(1'b0, IE_OFS, 16'h0008);
        transfer(1'b0, IME_OFS, 16'h0001);
        transfer(1'b0, TM0CNT_H, 16'h0018);
        wait_irq(1'b1, 40, "timer 0 overflow");
        exp_if = 16'h0008;
        transfer(1'b1, IF_OFS, '0);
        transfer(1'b0, IME_OFS, 16'h0000);
        transfer(1'b0, IF_OFS, 16'h0008);
        repeat (40) begin
            @(negedge gba_clk);
            check_value("irq", {15'h0, irq}, 16'h0000);
        end
        transfer(1'b1, IF_OFS, '0);

        // Zeros leave IF pending, bit 3 clears it
        transfer(1'b0, TM0CNT_H, 16'h0008);
        transfer(1'b0, IME_OFS, 16'h0001);
        wait_irq(1'b1, 10, "pending IF after IME set");
        transfer(1'b0, IF_OFS, 16'h0000);
        transfer(1'b1, IF_OFS, '0);
        check_value("irq", {15'h0, irq}, 16'h0001);
        transfer(1'b0, IF_OFS, 16'h0008);
        wait_irq(1'b0, 10, "IF acknowledge");
        exp_if = 16'h0000;
        transfer(1'b1, IF_OFS, '0);

        // Timer 1 counts timer 0 overflows, kept clear of its own wrap
        reload1 = 16'($random(seed)) & 16'h7fff;
        transfer(1'b0, TM1CNT_L, reload1);
        transfer(1'b0, TM1CNT_H, 16'h0014);
        transfer(1'b0, TM0CNT_L, 16'hff00);
        transfer(1'b0, TM0CNT_H, 16'h0018);
        for (int i = 0; i < NUM_ACKS; i++) begin
            wait_irq(1'b1, 300, "cascade overflow");
            if (irq) begin
                transfer(1'b0, IF_OFS, 16'h0008);
                acks++;
            end
            wait_irq(1'b0, 10, "cascade acknowledge");
        end
        transfer(1'b0, TM0CNT_H, 16'h0008);
        exp_count[1] = reload1 + 16'(acks);
        transfer(1'b1, TM1CNT_L, '0);
        transfer(1'b1, TM1CNT_H, '0);

        repeat (4) @(negedge gba_clk);
        if (exp_q.size() != 0) begin
            $display("ERROR: %0d read responses never arrived", exp_q.size());
            other_errors++;
        end
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    // Bound on the whole run, from the test lengths above
    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        other_errors++;
        $display("ERROR: timeout, the run did not finish within %0d cycles", RUN_CYCLES);
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        $display("test failed");
        $finish;
    end

endmodule

// File: gba_io_top.f
+incdir+verilog
verilog/gba_bus_pkg.sv
verilog/gba_periph_pkg.sv
verilog/io_reg_file.sv
verilog/timer_bank.sv
verilog/interrupt_controller.sv
verilog/gba_io_top.sv
tests/gba_io_chk.sv
tests/gba_io_tb.sv
